//--- rv_mc_core.f
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_ctrl_if.sv
rv_alu.sv
rv_regfile.sv
rv_control.sv
rv_datapath.sv
rv_mc_core.sv
rv_mc_core_assertions.sv
tb_rv_mc_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_mc_core
FILELIST  ?= rv_mc_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_rv_mc_core.sv
`default_nettype none

`include "rv_mc_defs.svh"

module tb_rv_mc_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCASES       = 7;
    localparam int MAX_WORDS    = 12;
    localparam int MAX_STORES   = 4;
    localparam int RST_CYCLES   = 10;
    localparam int HALT_TIMEOUT = 200;
    localparam int DMEM_WORDS   = 32;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   prog_we;
    logic [`RV_IMEM_AW-1:0] prog_addr;
    logic [31:0]            prog_data;
    logic [`RV_XLEN-1:0]    dmem_addr;
    logic [`RV_XLEN-1:0]    dmem_wdata;
    logic                   dmem_re;
    logic                   dmem_we;
    logic [`RV_XLEN-1:0]    dmem_rdata;
    logic                   halted;

    // stimulus and expected values, one row per case
    logic [31:0] prog_tab  [NCASES][MAX_WORDS];
    int          nwords    [NCASES];
    logic [63:0] exp_addr  [NCASES][MAX_STORES];
    logic [63:0] exp_data  [NCASES][MAX_STORES];
    int          nstores   [NCASES];
    int          exp_reads [NCASES];
    bit          has_pre   [NCASES];
    logic [63:0] pre_addr  [NCASES];
    logic [63:0] pre_data  [NCASES];
    int          abort_cyc [NCASES];

    // data memory model and observed traffic
    logic [63:0] dmem [DMEM_WORDS];
    logic [63:0] st_addr_q [$];
    logic [63:0] st_data_q [$];
    int          rd_count = 0;
    bit          rd_pend  = 1'b0;
    logic [63:0] rd_addr;

    int err_count   = 0;
    int check_count = 0;

    rv_mc_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halted     (halted)
    );

    always #4 clk = ~clk;

    // strobes sampled mid-cycle, stores also update the model
    always @(negedge clk) begin
        if (dmem_we) begin
            st_addr_q.push_back(dmem_addr);
            st_data_q.push_back(dmem_wdata);
            dmem[dmem_addr[7:3]] = dmem_wdata;
        end
        if (dmem_re) begin
            rd_count++;
            rd_addr = dmem_addr;
            rd_pend = 1'b1;
        end
    end

    // read data appears after the edge that ends MEMORY
    always @(posedge clk) begin
        #1;
        if (rd_pend) begin
            dmem_rdata = dmem[rd_addr[7:3]];
            rd_pend    = 1'b0;
        end
    end

    // RV64I encodings
    function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] ld(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sd(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b011, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    task automatic push_instr(input int c, input logic [31:0] w);
        prog_tab[c][nwords[c]] = w;
        nwords[c]++;
    endtask

    task automatic expect_store(input int c, input logic [63:0] a, input logic [63:0] d);
        exp_addr[c][nstores[c]] = a;
        exp_data[c][nstores[c]] = d;
        nstores[c]++;
    endtask

    task automatic build_table();
        int c;
        for (c = 0; c < NCASES; c++) begin
            nwords[c]    = 0;
            nstores[c]   = 0;
            exp_reads[c] = 0;
            has_pre[c]   = 1'b0;
            pre_addr[c]  = '0;
            pre_data[c]  = '0;
            abort_cyc[c] = 0;
        end
        // add, sub, and, or on 25 and -9
        push_instr(0, addi(1, 0, 25));
        push_instr(0, addi(2, 0, -9));
        push_instr(0, rtype(0, 0, 3, 1, 2));
        push_instr(0, rtype(32, 0, 4, 1, 2));
        push_instr(0, rtype(0, 7, 5, 1, 2));
        push_instr(0, rtype(0, 6, 6, 1, 2));
        push_instr(0, sd(3, 0, 0));
        push_instr(0, sd(4, 0, 8));
        push_instr(0, sd(5, 0, 16));
        push_instr(0, sd(6, 0, 24));
        push_instr(0, EBREAK);
        expect_store(0, 64'd0, 64'd16);
        expect_store(0, 64'd8, 64'd34);
        expect_store(0, 64'd16, 64'd17);
        expect_store(0, 64'd24, 64'hFFFF_FFFF_FFFF_FFFF);
        // signed slt, negative immediates, x0 stays zero
        push_instr(1, addi(1, 0, -5));
        push_instr(1, addi(2, 0, 3));
        push_instr(1, rtype(0, 2, 3, 1, 2));
        push_instr(1, rtype(0, 2, 4, 2, 1));
        push_instr(1, addi(0, 0, 99));
        push_instr(1, addi(5, 1, -2048));
        push_instr(1, sd(3, 0, 32));
        push_instr(1, sd(4, 0, 40));
        push_instr(1, sd(0, 0, 48));
        push_instr(1, sd(5, 0, 56));
        push_instr(1, EBREAK);
        expect_store(1, 64'd32, 64'd1);
        expect_store(1, 64'd40, 64'd0);
        expect_store(1, 64'd48, 64'd0);
        expect_store(1, 64'd56, 64'hFFFF_FFFF_FFFF_F7FB);
        // store then load back, plus a preset word
        has_pre[2]  = 1'b1;
        pre_addr[2] = 64'd128;
        pre_data[2] = 64'h0123_4567_89AB_CDEF;
        push_instr(2, addi(1, 0, -1000));
        push_instr(2, addi(2, 0, 64));
        push_instr(2, sd(1, 2, 8));
        push_instr(2, ld(3, 2, 8));
        push_instr(2, sd(3, 2, 16));
        push_instr(2, ld(4, 0, 128));
        push_instr(2, sd(4, 0, 88));
        push_instr(2, EBREAK);
        expect_store(2, 64'd72, 64'hFFFF_FFFF_FFFF_FC18);
        expect_store(2, 64'd80, 64'hFFFF_FFFF_FFFF_FC18);
        expect_store(2, 64'd88, 64'h0123_4567_89AB_CDEF);
        exp_reads[2] = 2;
        // beq not taken, taken, then unconditional
        push_instr(3, addi(1, 0, 5));
        push_instr(3, addi(2, 0, 5));
        push_instr(3, addi(3, 0, 6));
        push_instr(3, beq(1, 3, 8));
        push_instr(3, sd(1, 0, 96));
        push_instr(3, beq(1, 2, 12));
        push_instr(3, sd(3, 0, 104));
        push_instr(3, sd(3, 0, 112));
        push_instr(3, sd(2, 0, 120));
        push_instr(3, beq(0, 0, 8));
        push_instr(3, sd(1, 0, 96));
        push_instr(3, EBREAK);
        expect_store(3, 64'd96, 64'd5);
        expect_store(3, 64'd120, 64'd5);
        // jal forward, jalr back to an odd target, jal link after it
        push_instr(4, jal(1, 12));
        push_instr(4, jal(7, 16));
        push_instr(4, EBREAK);
        push_instr(4, sd(1, 0, 136));
        push_instr(4, jalr(5, 1, 1));
        push_instr(4, sd(5, 0, 144));
        push_instr(4, sd(7, 0, 152));
        push_instr(4, EBREAK);
        expect_store(4, 64'd136, 64'd4);
        expect_store(4, 64'd144, 64'd20);
        expect_store(4, 64'd152, 64'd8);
        // endless store loop, cut short by reset
        push_instr(5, addi(1, 1, 1));
        push_instr(5, sd(1, 0, 0));
        push_instr(5, beq(0, 0, -8));
        abort_cyc[5] = 30;
        // restarts at pc 0 with cleared registers
        push_instr(6, addi(2, 0, 77));
        push_instr(6, sd(2, 0, 160));
        push_instr(6, sd(1, 0, 168));
        push_instr(6, EBREAK);
        expect_store(6, 64'd160, 64'd77);
        expect_store(6, 64'd168, 64'd0);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    // hold reset, write the program, refill data memory
    task automatic load_program(input int c);
        int k;
        int i;
        int total;
        total = (nwords[c] > RST_CYCLES - 1) ? nwords[c] : RST_CYCLES - 1;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (k = 0; k < total; k++) begin
            @(posedge clk);
            #1;
            if (k < nwords[c]) begin
                prog_we   = 1'b1;
                prog_addr = k[`RV_IMEM_AW-1:0];
                prog_data = prog_tab[c][k];
            end else begin
                prog_we = 1'b0;
            end
            @(negedge clk);
            compare("dmem_we in reset", 64'(dmem_we), 64'd0);
            compare("dmem_re in reset", 64'(dmem_re), 64'd0);
            compare("halted in reset", 64'(halted), 64'd0);
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {$urandom(), $urandom()};
        end
        if (has_pre[c]) begin
            dmem[pre_addr[c][7:3]] = pre_data[c];
        end
        st_addr_q.delete();
        st_data_q.delete();
        rd_count = 0;
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        rst     = 1'b0;
    endtask

    task automatic wait_halt(input int c, output bit timed_out);
        int cyc;
        timed_out = 1'b1;
        for (cyc = 0; cyc < HALT_TIMEOUT; cyc++) begin
            @(negedge clk);
            if (halted) begin
                timed_out = 1'b0;
                break;
            end
        end
        if (timed_out) begin
            err_count++;
            $display("timeout: case %0d did not halt within %0d cycles", c, HALT_TIMEOUT);
        end
    endtask

    task automatic check_case(input int c);
        int i;
        compare($sformatf("case %0d store count", c), 64'(st_addr_q.size()), 64'(nstores[c]));
        for (i = 0; i < nstores[c] && i < st_addr_q.size(); i++) begin
            compare($sformatf("case %0d dmem_addr[%0d]", c, i), st_addr_q[i], exp_addr[c][i]);
            compare($sformatf("case %0d dmem_wdata[%0d]", c, i), st_data_q[i], exp_data[c][i]);
        end
        compare($sformatf("case %0d dmem_re count", c), 64'(rd_count), 64'(exp_reads[c]));
    endtask

    initial begin
        int  c;
        int  cyc;
        int  asrt;
        bit  timed_out;
        rst        = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        dmem_rdata = '0;
        void'($urandom(32'h1327));
        build_table();
        timed_out = 1'b0;
        for (c = 0; c < NCASES && !timed_out; c++) begin
            load_program(c);
            if (abort_cyc[c] > 0) begin
                // let it run, the next case resets it mid-loop
                for (cyc = 0; cyc < abort_cyc[c]; cyc++) begin
                    @(posedge clk);
                end
            end else begin
                wait_halt(c, timed_out);
                if (!timed_out) begin
                    check_case(c);
                end
            end
        end
        asrt = int'(u_dut.u_control.u_assertions.fail_count);
        if (asrt != 0) begin
            err_count += asrt;
            $display("%0d concurrent assertion failure(s) were reported", asrt);
        end
        $display("checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_mc_core_assertions.sv
`default_nettype none

module rv_mc_core_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    halted,
    input logic                    reg_we,
    input logic                    mem_re,
    input logic                    mem_we,
    input rv_ctrl_pkg::fsm_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;

    import rv_ctrl_pkg::*;

    // read back by the testbench at the end of the run
    int unsigned fail_count = 0;

    // data port never reads and writes in one cycle
    mem_strobes_exclusive: assert property (@(posedge clk) !(mem_re && mem_we))
        else begin
            fail_count++;
            $error("dmem_re and dmem_we high in the same cycle");
        end

    // register writes only in writeback
    reg_write_in_wb: assert property (
        @(posedge clk) disable iff (rst) reg_we |-> (state == WRITEBACK))
        else begin
            fail_count++;
            $error("reg_we high outside WRITEBACK, state %0d", state);
        end

    // halted holds until the next reset
    halt_is_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            fail_count++;
            $error("halted fell without a reset");
        end

endmodule

bind rv_control rv_mc_core_assertions u_assertions (
    .clk    (clk),
    .rst    (rst),
    .halted (halted),
    .reg_we (cif.reg_we),
    .mem_re (cif.mem_re),
    .mem_we (cif.mem_we),
    .state  (state_q)
);

`default_nettype wire

//--- rv_mc_core.sv
`default_nettype none

`include "rv_mc_defs.svh"

module rv_mc_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prog_we,
    input  logic [`RV_IMEM_AW-1:0] prog_addr,
    input  logic [31:0]            prog_data,
    output logic [`RV_XLEN-1:0]    dmem_addr,
    output logic [`RV_XLEN-1:0]    dmem_wdata,
    output logic                   dmem_re,
    output logic                   dmem_we,
    input  logic [`RV_XLEN-1:0]    dmem_rdata,
    output logic                   halted
);

    // control and status between FSM and datapath
    rv_ctrl_if cif ();

    rv_control u_control (
        .clk    (clk),
        .rst    (rst),
        .halted (halted),
        .cif    (cif.ctrl)
    );

    rv_datapath u_datapath (
        .clk        (clk),
        .rst        (rst),
        .cif        (cif.dp),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    // memory strobes come straight from the FSM
    assign dmem_re = cif.mem_re;
    assign dmem_we = cif.mem_we;

endmodule

`default_nettype wire

//--- rv_datapath.sv
`default_nettype none

`include "rv_mc_defs.svh"

module rv_datapath (
    input  logic                   clk,
    input  logic                   rst,
    rv_ctrl_if.dp                  cif,
    input  logic                   prog_we,
    input  logic [`RV_IMEM_AW-1:0] prog_addr,
    input  logic [31:0]            prog_data,
    output logic [`RV_XLEN-1:0]    dmem_addr,
    output logic [`RV_XLEN-1:0]    dmem_wdata,
    input  logic [`RV_XLEN-1:0]    dmem_rdata
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [31:0]         imem [`RV_IMEM_WORDS];
    instr_t              ir_q;
    logic [31:0]         ir;
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_cur_q;
    logic [`RV_XLEN-1:0] a_q;
    logic [`RV_XLEN-1:0] b_q;
    logic [`RV_XLEN-1:0] alu_out_q;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rdata_a;
    logic [`RV_XLEN-1:0] rdata_b;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] br_target;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] wb_data;

    // program load only while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // pc_cur keeps the address of the instruction in ir
    always_ff @(posedge clk) begin
        if (cif.ir_load) begin
            ir_q     <= imem[pc_q[`RV_IMEM_AW+1:2]];
            pc_cur_q <= pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (cif.pc_load) begin
            pc_q <= pc_next;
        end
    end

    // operand and result latches between states
    always_ff @(posedge clk) begin
        a_q       <= rdata_a;
        b_q       <= rdata_b;
        alu_out_q <= alu_result;
    end

    assign ir = ir_q;

    // immediate formats, sign-extended
    always_comb begin
        case (ir_q.opcode)
            OPC_STORE:  imm = {{52{ir[31]}}, ir[31:25], ir[11:7]};
            OPC_BRANCH: imm = {{51{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            OPC_JAL:    imm = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:    imm = {{52{ir[31]}}, ir[31:20]};
        endcase
    end

    rv_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .we      (cif.reg_we),
        .waddr   (ir_q.rd),
        .wdata   (wb_data),
        .raddr_a (ir_q.rs1),
        .raddr_b (ir_q.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign alu_a = (cif.src_a == SRC_A_PC) ? pc_q : a_q;

    always_comb begin
        case (cif.src_b)
            SRC_B_IMM:  alu_b = imm;
            SRC_B_FOUR: alu_b = `RV_XLEN'd4;
            default:    alu_b = b_q;
        endcase
    end

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (cif.alu_op),
        .result (alu_result),
        .zero   (cif.alu_zero)
    );

    // beq and jal share this adder, imm format differs
    assign br_target = pc_cur_q + imm;
    assign link      = pc_cur_q + `RV_XLEN'd4;

    // jalr target has bit 0 cleared
    always_comb begin
        if (cif.pc_sel_jalr) begin
            pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
        end else if (cif.pc_sel_branch) begin
            pc_next = br_target;
        end else begin
            pc_next = alu_result;
        end
    end

    // load data taken straight off the port in writeback
    always_comb begin
        case (cif.wb_sel)
            WB_MEM:  wb_data = dmem_rdata;
            WB_PC4:  wb_data = link;
            default: wb_data = alu_out_q;
        endcase
    end

    // decode fields back to the FSM
    assign cif.opcode = ir_q.opcode;
    assign cif.funct3 = ir_q.funct3;
    assign cif.funct7 = ir_q.funct7;

    assign dmem_addr  = alu_out_q;
    assign dmem_wdata = b_q;

endmodule

`default_nettype wire

//--- rv_control.sv
`default_nettype none

module rv_control (
    input  logic   clk,
    input  logic   rst,
    output logic   halted,
    rv_ctrl_if.ctrl cif
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    fsm_state_e state_q;
    fsm_state_e state_d;
    logic       supported;

    // legal encodings of the subset, anything else halts
    always_comb begin
        case (cif.opcode)
            OPC_OP: begin
                supported = ((cif.funct7 == F7_BASE) &&
                             (cif.funct3 inside {F3_ADD_SUB, F3_SLT, F3_OR, F3_AND})) ||
                            ((cif.funct7 == F7_SUB) && (cif.funct3 == F3_ADD_SUB));
            end
            OPC_OP_IMM: supported = (cif.funct3 == F3_ADD_SUB);
            OPC_LOAD:   supported = (cif.funct3 == F3_LD);
            OPC_STORE:  supported = (cif.funct3 == F3_SD);
            OPC_BRANCH: supported = (cif.funct3 == F3_BEQ);
            OPC_JAL:    supported = 1'b1;
            OPC_JALR:   supported = (cif.funct3 == F3_JALR);
            // ebreak lands here too
            default:    supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        // defaults, all strobes low
        state_d           = state_q;
        cif.ir_load       = 1'b0;
        cif.pc_load       = 1'b0;
        cif.pc_sel_branch = 1'b0;
        cif.pc_sel_jalr   = 1'b0;
        cif.alu_op        = ALU_ADD;
        cif.src_a         = SRC_A_RS1;
        cif.src_b         = SRC_B_RS2;
        cif.wb_sel        = WB_ALU;
        cif.reg_we        = 1'b0;
        cif.mem_re        = 1'b0;
        cif.mem_we        = 1'b0;

        case (state_q)
            IDLE: state_d = FETCH;
            FETCH: begin
                // ir from imem, pc advanced by 4 through the alu
                cif.ir_load = 1'b1;
                cif.pc_load = 1'b1;
                cif.src_a   = SRC_A_PC;
                cif.src_b   = SRC_B_FOUR;
                state_d     = DECODE;
            end
            DECODE: state_d = supported ? EXECUTE : HALT;
            EXECUTE: begin
                case (cif.opcode)
                    OPC_OP: begin
                        if (cif.funct7 == F7_SUB) begin
                            cif.alu_op = ALU_SUB;
                        end else begin
                            case (cif.funct3)
                                F3_SLT:  cif.alu_op = ALU_SLT;
                                F3_OR:   cif.alu_op = ALU_OR;
                                F3_AND:  cif.alu_op = ALU_AND;
                                default: cif.alu_op = ALU_ADD;
                            endcase
                        end
                        state_d = WRITEBACK;
                    end
                    OPC_OP_IMM: begin
                        cif.src_b = SRC_B_IMM;
                        state_d   = WRITEBACK;
                    end
                    OPC_LOAD, OPC_STORE: begin
                        // effective address
                        cif.src_b = SRC_B_IMM;
                        state_d   = MEMORY;
                    end
                    OPC_BRANCH: begin
                        cif.alu_op        = ALU_SUB;
                        cif.pc_load       = cif.alu_zero;
                        cif.pc_sel_branch = 1'b1;
                        state_d           = FETCH;
                    end
                    OPC_JAL: begin
                        cif.pc_load       = 1'b1;
                        cif.pc_sel_branch = 1'b1;
                        state_d           = WRITEBACK;
                    end
                    OPC_JALR: begin
                        cif.src_b       = SRC_B_IMM;
                        cif.pc_load     = 1'b1;
                        cif.pc_sel_jalr = 1'b1;
                        state_d         = WRITEBACK;
                    end
                    default: state_d = HALT;
                endcase
            end
            MEMORY: begin
                if (cif.opcode == OPC_LOAD) begin
                    cif.mem_re = 1'b1;
                    state_d    = WRITEBACK;
                end else begin
                    // sd retires here
                    cif.mem_we = 1'b1;
                    state_d    = FETCH;
                end
            end
            WRITEBACK: begin
                cif.reg_we = 1'b1;
                case (cif.opcode)
                    OPC_LOAD:          cif.wb_sel = WB_MEM;
                    OPC_JAL, OPC_JALR: cif.wb_sel = WB_PC4;
                    default:           cif.wb_sel = WB_ALU;
                endcase
                state_d = FETCH;
            end
            // parked until reset
            HALT: state_d = HALT;
            default: state_d = IDLE;
        endcase
    end

    assign halted = (state_q == HALT);

endmodule

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

`include "rv_mc_defs.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t waddr,
    input  logic [`RV_XLEN-1:0]  wdata,
    input  rv_isa_pkg::reg_idx_t raddr_a,
    input  rv_isa_pkg::reg_idx_t raddr_b,
    output logic [`RV_XLEN-1:0]  rdata_a,
    output logic [`RV_XLEN-1:0]  rdata_b
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // cleared on reset so every program starts from zeros
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 hardwired
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- rv_alu.sv
`default_nettype none

`include "rv_mc_defs.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_ctrl_pkg::alu_op_e op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);
    import rv_ctrl_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // signed compare, result is 0 or 1
            ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    // beq decides on this after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rv_ctrl_if.sv
`default_nettype none

interface rv_ctrl_if;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // control toward the datapath
    logic    ir_load;
    logic    pc_load;
    logic    pc_sel_branch;
    logic    pc_sel_jalr;
    alu_op_e alu_op;
    src_a_e  src_a;
    src_b_e  src_b;
    wb_sel_e wb_sel;
    logic    reg_we;
    logic    mem_re;
    logic    mem_we;

    // decode fields and status back to the FSM
    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    alu_zero;

    modport ctrl (
        output ir_load, pc_load, pc_sel_branch, pc_sel_jalr,
        output alu_op, src_a, src_b, wb_sel, reg_we, mem_re, mem_we,
        input  opcode, funct3, funct7, alu_zero
    );

    modport dp (
        input  ir_load, pc_load, pc_sel_branch, pc_sel_jalr,
        input  alu_op, src_a, src_b, wb_sel, reg_we, mem_re, mem_we,
        output opcode, funct3, funct7, alu_zero
    );

endinterface

`default_nettype wire

//--- rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // multicycle sequencer states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXECUTE   = 3'd3,
        MEMORY    = 3'd4,
        WRITEBACK = 3'd5,
        HALT      = 3'd6
    } fsm_state_e;

    // alu operations
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    // alu operand a
    typedef enum logic {
        SRC_A_RS1 = 1'b0,
        SRC_A_PC  = 1'b1
    } src_a_e;

    // alu operand b
    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'd0,
        SRC_B_IMM  = 2'd1,
        SRC_B_FOUR = 2'd2
    } src_b_e;

    // register file write source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // instruction field types
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_idx_t;

    // funct3 selectors
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LD      = 3'b011;
    localparam funct3_t F3_SD      = 3'b011;
    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_JALR    = 3'b000;

    // funct7 selectors for OP
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_SUB  = 7'b0100000;

    // 32-bit instruction word, R-type field layout
    typedef struct packed {
        funct7_t  funct7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        funct3_t  funct3;
        reg_idx_t rd;
        opcode_e  opcode;
    } instr_t;

endpackage

`default_nettype wire

//--- rv_mc_defs.svh
`ifndef RV_MC_DEFS_SVH
`define RV_MC_DEFS_SVH

// data path and address width
`define RV_XLEN 64

// architectural integer registers, x0 included
`define RV_NREGS 32

// instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 64

// word address width of the instruction memory
`define RV_IMEM_AW ($clog2(`RV_IMEM_WORDS))

`endif
